//--- build.f
+incdir+include
rtl/regCtl_pkg.sv
rtl/axiLiteBridge.sv
rtl/paramRegBank.sv
rtl/regCtlTop.sv
dv/regCtl_sva.sv
dv/regCtl_tb.sv

//--- Makefile
# Verilator build and run of the register control port testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP       := regCtl_tb
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dv/regCtl_tb.sv
//----------------------------------------------------------
// Directed tests of the AXI4-Lite register port
// Model keeps one staged lower word and one kept upper half
// A timeout stops all further bus traffic and checks
//----------------------------------------------------------
`timescale 1ns/1ns
`include "regCtl_consts.svh"

module regCtl_tb;

	localparam int WAIT_LIMIT = 100;

	logic aclk;
	logic rst;
	logic awvalid;
	logic awready;
	regCtl_pkg::axiAddr_t awAddr;
	logic wvalid;
	logic wready;
	regCtl_pkg::axiWData_t wData;
	logic bvalid;
	logic bready;
	regCtl_pkg::axiResp_e bresp;
	logic arvalid;
	logic arready;
	regCtl_pkg::axiAddr_t arAddr;
	logic rvalid;
	logic rready;
	logic [`BUS_DATA_W-1:0] rdata;
	regCtl_pkg::axiResp_e rresp;

	// Reference model
	logic [`REG_DATA_W-1:0] model [`REG_COUNT-1];
	logic [`BUS_DATA_W-1:0] stagedLo;
	logic [`BUS_DATA_W-1:0] keptHi;
	integer seed;
	int errors;
	int checks;
	bit timedOut;
	string testName;

	regCtlTop UUT (.*);

	// 40 ns period
	always #20 aclk = ~aclk;

	//----------------------------------------------------------
	// Helpers
	//----------------------------------------------------------
	function automatic int pick(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// Byte address is {index, fold, byte select}
	function automatic regCtl_pkg::axiAddr_t busAddr(int idx, int fold);
		regCtl_pkg::axiAddr_t a;
		a.addr = {`REG_IDX_W'(idx), `FSEL_W'(fold), `BSEL_W'(0)};
		a.prot = 3'(pick(8));
		return a;
	endfunction

	task automatic checkVal(string what, logic [`BUS_DATA_W-1:0] exp,
			logic [`BUS_DATA_W-1:0] act);
		if (!timedOut) begin
			checks++;
			assert (act === exp)
			else begin
				$display("CHECK FAILED %s, %s: expected %h, actual %h",
					testName, what, exp, act);
				errors++;
			end
		end
	endtask

	task automatic timeoutHit(string what);
		$display("Timeout in %s: no %s within %0d cycles", testName, what, WAIT_LIMIT);
		errors++;
		timedOut = 1'b1;
	endtask

	//----------------------------------------------------------
	// Bus drivers
	//----------------------------------------------------------
	// AW and W each start after their own gap, B is taken after bDly
	task automatic axiWrite(int idx, int fold, logic [`BUS_DATA_W-1:0] word,
			int awDly, int wDly, int bDly, output regCtl_pkg::axiResp_e resp);
		int cyc;
		bit awDone;
		bit wDone;
		bit bDone;
		resp = regCtl_pkg::RESP_OKAY;
		if (timedOut)
			return;
		cyc = 0;
		awDone = 1'b0;
		wDone = 1'b0;
		bDone = 1'b0;
		while (!(awDone && wDone) && cyc < WAIT_LIMIT) begin
			if (cyc == awDly) begin
				awvalid <= 1'b1;
				awAddr <= busAddr(idx, fold);
			end
			if (cyc == wDly) begin
				wvalid <= 1'b1;
				wData <= '{data: word, strb: '1};
			end
			@(posedge aclk);
			if (awvalid && awready) begin
				awDone = 1'b1;
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				wDone = 1'b1;
				wvalid <= 1'b0;
			end
			cyc++;
		end
		if (!(awDone && wDone))
			timeoutHit("write address or data handshake");
		cyc = 0;
		while (!timedOut && !bDone && cyc < WAIT_LIMIT) begin
			if (cyc == bDly)
				bready <= 1'b1;
			@(posedge aclk);
			// Both captures stay full until B is taken
			checkVal("write readies while B pending", 32'(0), 32'({awready, wready}));
			if (bvalid && bready) begin
				bDone = 1'b1;
				resp = bresp;
				bready <= 1'b0;
			end
			cyc++;
		end
		if (!timedOut && !bDone)
			timeoutHit("write response");
	endtask

	task automatic axiRead(int idx, int fold, int arDly, int rDly,
			output logic [`BUS_DATA_W-1:0] word, output regCtl_pkg::axiResp_e resp);
		int cyc;
		bit arDone;
		bit rDone;
		word = '0;
		resp = regCtl_pkg::RESP_OKAY;
		if (timedOut)
			return;
		cyc = 0;
		arDone = 1'b0;
		rDone = 1'b0;
		while (!arDone && cyc < WAIT_LIMIT) begin
			if (cyc == arDly) begin
				arvalid <= 1'b1;
				arAddr <= busAddr(idx, fold);
			end
			@(posedge aclk);
			if (arvalid && arready) begin
				arDone = 1'b1;
				arvalid <= 1'b0;
			end
			cyc++;
		end
		if (!arDone)
			timeoutHit("read address handshake");
		cyc = 0;
		while (!timedOut && !rDone && cyc < WAIT_LIMIT) begin
			if (cyc == rDly)
				rready <= 1'b1;
			@(posedge aclk);
			// Read capture stays full until R is taken
			checkVal("arready while R pending", 32'(0), 32'(arready));
			if (rvalid && rready) begin
				rDone = 1'b1;
				word = rdata;
				resp = rresp;
				rready <= 1'b0;
			end
			cyc++;
		end
		if (!timedOut && !rDone)
			timeoutHit("read data");
	endtask

	//----------------------------------------------------------
	// Model-checked accesses
	//----------------------------------------------------------
	// Lower words stage, upper words commit, bad indices do nothing
	task automatic writeWord(int idx, int fold, logic [`BUS_DATA_W-1:0] word,
			int awDly = 0, int wDly = 0, int bDly = 0);
		regCtl_pkg::axiResp_e resp;
		regCtl_pkg::axiResp_e expResp;
		expResp = (idx < `REG_COUNT) ? regCtl_pkg::RESP_OKAY : regCtl_pkg::RESP_SLVERR;
		if (idx < `REG_COUNT && fold == 0)
			stagedLo = word;
		else if (idx < `REG_COUNT-1)
			model[idx] = {word, stagedLo};
		axiWrite(idx, fold, word, awDly, wDly, bDly, resp);
		checkVal($sformatf("bresp r%0d.%0d", idx, fold), 32'(expResp), 32'(resp));
	endtask

	// Lower reads refresh the kept upper half, upper reads return it
	task automatic readWord(int idx, int fold, int arDly = 0, int rDly = 0);
		logic [`REG_DATA_W-1:0] full;
		logic [`BUS_DATA_W-1:0] expData;
		logic [`BUS_DATA_W-1:0] act;
		regCtl_pkg::axiResp_e expResp;
		regCtl_pkg::axiResp_e resp;
		expResp = regCtl_pkg::RESP_OKAY;
		expData = '0;
		if (idx >= `REG_COUNT) begin
			expResp = regCtl_pkg::RESP_SLVERR;
		end else if (fold == 0) begin
			if (idx == `REG_COUNT-1)
				full = `ID_VALUE;
			else
				full = model[idx];
			expData = full[`BUS_DATA_W-1:0];
			keptHi = full[`REG_DATA_W-1:`BUS_DATA_W];
		end else begin
			expData = keptHi;
		end
		axiRead(idx, fold, arDly, rDly, act, resp);
		checkVal($sformatf("rdata r%0d.%0d", idx, fold), expData, act);
		checkVal($sformatf("rresp r%0d.%0d", idx, fold), 32'(expResp), 32'(resp));
	endtask

	//----------------------------------------------------------
	// Tests
	//----------------------------------------------------------
	task automatic testReset();
		testName = "reset state";
		// All capture registers empty out of reset
		checkVal("readies after reset", 32'(3'b111), 32'({awready, wready, arready}));
		for (int i = 0; i < `REG_COUNT-1; i++) begin
			readWord(i, 0);
			readWord(i, 1);
		end
	endtask

	task automatic testFolded();
		testName = "folded write and read";
		for (int i = 0; i < `REG_COUNT-1; i++) begin
			writeWord(i, 0, $random(seed));
			writeWord(i, 1, $random(seed));
		end
		for (int i = 0; i < `REG_COUNT-1; i++) begin
			readWord(i, 0);
			readWord(i, 1);
		end
	endtask

	// Lower write alone must not reach the bank
	task automatic testStaging();
		testName = "staging rule";
		writeWord(2, 0, $random(seed));
		readWord(2, 0);
		readWord(2, 1);
		writeWord(2, 1, $random(seed));
		readWord(2, 0);
		readWord(2, 1);
	endtask

	// Upper read after a rewrite still sees the earlier kept half
	task automatic testKeptUpper();
		testName = "kept upper half";
		readWord(1, 0);
		writeWord(1, 0, $random(seed));
		writeWord(1, 1, $random(seed));
		readWord(1, 1);
		readWord(1, 0);
		readWord(1, 1);
	endtask

	task automatic testIdAndError();
		testName = "identification and error";
		readWord(4, 0);
		readWord(4, 1);
		writeWord(4, 0, $random(seed));
		writeWord(4, 1, $random(seed));
		readWord(4, 0);
		readWord(4, 1);
		for (int i = `REG_COUNT; i < 8; i++) begin
			writeWord(i, 0, $random(seed));
			writeWord(i, 1, $random(seed));
			readWord(i, 0);
			readWord(i, 1);
		end
	endtask

	// Random order, gaps and stalls on both reply channels
	task automatic testBackPressure();
		testName = "back-pressure";
		repeat (40) begin
			if (pick(2) == 0)
				writeWord(pick(8), pick(2), $random(seed), pick(6), pick(6), pick(8));
			else
				readWord(pick(8), pick(2), pick(4), pick(8));
		end
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial begin
		seed = 32'hca945961;
		errors = 0;
		checks = 0;
		timedOut = 1'b0;
		testName = "reset";
		stagedLo = '0;
		keptHi = '0;
		for (int i = 0; i < `REG_COUNT-1; i++)
			model[i] = '0;
		aclk = 1'b0;
		rst = 1'b1;
		awvalid = 1'b0;
		awAddr = '0;
		wvalid = 1'b0;
		wData = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		arAddr = '0;
		rready = 1'b0;
		repeat (8) @(posedge aclk);
		rst <= 1'b0;
		@(posedge aclk);
		testReset();
		testFolded();
		testStaging();
		testKeptUpper();
		testIdAndError();
		testBackPressure();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- dv/regCtl_sva.sv
//----------------------------------------------------------
// Protocol and reset assertions bound into regCtlTop
// Reset checks start one edge after rst is first sampled
//----------------------------------------------------------
`timescale 1ns/1ns
`include "regCtl_consts.svh"

module regCtl_sva (
	input logic                   aclk,
	input logic                   rst,
	input logic                   bvalid,
	input logic                   bready,
	input logic                   rvalid,
	input logic                   rready,
	input logic [`BUS_DATA_W-1:0] rdata,
	input logic                   ipEn,
	input regCtl_pkg::ipCmd_t     ipCmd
);

	// Replies stay quiet while reset is held
	resetQuiet: assert property (@(posedge aclk) rst |=> !bvalid && !rvalid)
		else $error("bvalid or rvalid high during reset");

	// Stalled R keeps valid and data
	rdataHold: assert property (@(posedge aclk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rdata or rvalid changed while rready was low");

	// Stalled B keeps valid
	bvalidHold: assert property (@(posedge aclk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped while bready was low");

	// Bank only sees implemented registers
	ipIdxRange: assert property (@(posedge aclk) disable iff (rst)
		ipEn |-> ipCmd.idx < `REG_IDX_W'(`REG_COUNT))
		else $error("bank strobed with an unimplemented register index");

endmodule

bind regCtlTop regCtl_sva uSva (
	.aclk(aclk),
	.rst(rst),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.ipEn(ipEn),
	.ipCmd(ipCmd)
);

//--- rtl/regCtlTop.sv
//----------------------------------------------------------
// AXI4-Lite register port with its 64-bit parameter bank
//----------------------------------------------------------
`timescale 1ns/1ns
`include "regCtl_consts.svh"

module regCtlTop (
	input  logic                   aclk,
	input  logic                   rst,
	input  logic                   awvalid,
	output logic                   awready,
	input  regCtl_pkg::axiAddr_t   awAddr,
	input  logic                   wvalid,
	output logic                   wready,
	input  regCtl_pkg::axiWData_t  wData,
	output logic                   bvalid,
	input  logic                   bready,
	output regCtl_pkg::axiResp_e   bresp,
	input  logic                   arvalid,
	output logic                   arready,
	input  regCtl_pkg::axiAddr_t   arAddr,
	output logic                   rvalid,
	input  logic                   rready,
	output logic [`BUS_DATA_W-1:0] rdata,
	output regCtl_pkg::axiResp_e   rresp
);

	// Bank interface
	logic ipEn;
	regCtl_pkg::ipCmd_t ipCmd;
	logic ipRAck;
	logic [`REG_DATA_W-1:0] ipRData;

	axiLiteBridge uBridge (
		.aclk, .rst,
		.awvalid, .awready, .awAddr,
		.wvalid, .wready, .wData,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .arAddr,
		.rvalid, .rready, .rdata, .rresp,
		.ipEn, .ipCmd, .ipRAck, .ipRData
	);

	paramRegBank uBank (
		.aclk, .rst,
		.ipEn, .ipCmd,
		.ipRAck, .ipRData
	);

endmodule

//--- rtl/paramRegBank.sv
//----------------------------------------------------------
// Four 64-bit read/write registers plus a read-only ID register
// Writes land on the ipEn edge, reads acknowledge one cycle later
//----------------------------------------------------------
`timescale 1ns/1ns
`include "regCtl_consts.svh"

module paramRegBank (
	input  logic                   aclk,
	input  logic                   rst,
	input  logic                   ipEn,
	input  regCtl_pkg::ipCmd_t     ipCmd,
	output logic                   ipRAck,
	output logic [`REG_DATA_W-1:0] ipRData
);

	// Writable registers sit below the ID index
	logic [`REG_DATA_W-1:0] regs [`REG_COUNT-1];
	logic [`REG_DATA_W-1:0] rdVal;
	logic isRead;
	logic isWrite;

	assign isRead  = ipEn && (ipCmd.op == regCtl_pkg::IP_READ);
	assign isWrite = ipEn && (ipCmd.op == regCtl_pkg::IP_WRITE);

	//----------------------------------------------------------
	// Storage
	//----------------------------------------------------------
	// ID index and above never match, so those writes drop
	always_ff @(posedge aclk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT-1; i++)
				regs[i] <= '0;
		end else if (isWrite) begin
			for (int i = 0; i < `REG_COUNT-1; i++) begin
				if (ipCmd.idx == `REG_IDX_W'(i))
					regs[i] <= ipCmd.wdata;
			end
		end
	end

	//----------------------------------------------------------
	// Read path
	//----------------------------------------------------------
	// Unmapped indices read as zero
	always_comb begin
		rdVal = '0;
		for (int i = 0; i < `REG_COUNT-1; i++) begin
			if (ipCmd.idx == `REG_IDX_W'(i))
				rdVal = regs[i];
		end
		if (ipCmd.idx == `REG_IDX_W'(`REG_COUNT-1))
			rdVal = `ID_VALUE;
	end

	// One-cycle acknowledge
	always_ff @(posedge aclk) begin
		if (rst)
			ipRAck <= 1'b0;
		else
			ipRAck <= isRead;
	end

	// Data holds between reads
	always_ff @(posedge aclk) begin
		if (isRead)
			ipRData <= rdVal;
	end

endmodule

//--- rtl/axiLiteBridge.sv
//----------------------------------------------------------
// AXI4-Lite subordinate folding 32-bit words onto 64-bit registers
// Lower-word writes only stage, the upper word commits all 64 bits
// Upper-word reads return the half kept by the last lower read
// One read and one write in flight, strobes and prot are ignored
//----------------------------------------------------------
`timescale 1ns/1ns
`include "regCtl_consts.svh"

module axiLiteBridge (
	input  logic                       aclk,
	input  logic                       rst,
	// Write address and data
	input  logic                       awvalid,
	output logic                       awready,
	input  regCtl_pkg::axiAddr_t       awAddr,
	input  logic                       wvalid,
	output logic                       wready,
	input  regCtl_pkg::axiWData_t      wData,
	// Write response
	output logic                       bvalid,
	input  logic                       bready,
	output regCtl_pkg::axiResp_e       bresp,
	// Read address and data
	input  logic                       arvalid,
	output logic                       arready,
	input  regCtl_pkg::axiAddr_t       arAddr,
	output logic                       rvalid,
	input  logic                       rready,
	output logic [`BUS_DATA_W-1:0]     rdata,
	output regCtl_pkg::axiResp_e       rresp,
	// Bank side
	output logic                       ipEn,
	output regCtl_pkg::ipCmd_t         ipCmd,
	input  logic                       ipRAck,
	input  logic [`REG_DATA_W-1:0]     ipRData
);

	// Capture registers
	logic awHeld;
	logic wHeld;
	logic arHeld;
	regCtl_pkg::axiAddr_t awAddrQ;
	regCtl_pkg::axiAddr_t arAddrQ;
	regCtl_pkg::axiWData_t wDataQ;

	// Address split and issue
	logic [`REG_IDX_W-1:0] wIdx;
	logic [`REG_IDX_W-1:0] rIdx;
	logic [`FSEL_W-1:0] wFold;
	logic [`FSEL_W-1:0] rFold;
	logic wInRange;
	logic rInRange;
	logic wrIssue;
	logic rdIssue;
	logic rLock;
	logic intAck;

	// Fold buffers
	logic [`FOLD-1:0][`BUS_DATA_W-1:0] wStage;
	logic [`FOLD-1:0][`BUS_DATA_W-1:0] commitData;
	logic [`FOLD-1:0][`BUS_DATA_W-1:0] rKeep;

	//----------------------------------------------------------
	// Request capture
	//----------------------------------------------------------
	// Write pair frees together once B is taken
	always_ff @(posedge aclk) begin
		if (rst) begin
			awHeld <= 1'b0;
			wHeld  <= 1'b0;
		end else if (bvalid && bready) begin
			awHeld <= 1'b0;
			wHeld  <= 1'b0;
		end else begin
			if (awvalid && awready)
				awHeld <= 1'b1;
			if (wvalid && wready)
				wHeld <= 1'b1;
		end
	end

	// Read address stays held until R is taken
	always_ff @(posedge aclk) begin
		if (rst)
			arHeld <= 1'b0;
		else if (rvalid && rready)
			arHeld <= 1'b0;
		else if (arvalid && arready)
			arHeld <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (awvalid && awready)
			awAddrQ <= awAddr;
		if (wvalid && wready)
			wDataQ <= wData;
		if (arvalid && arready)
			arAddrQ <= arAddr;
	end

	assign awready = !awHeld;
	assign wready  = !wHeld;
	assign arready = !arHeld;

	// Byte address is {index, fold, byte select}
	assign wIdx  = awAddrQ.addr[`BSEL_W+`FSEL_W +: `REG_IDX_W];
	assign rIdx  = arAddrQ.addr[`BSEL_W+`FSEL_W +: `REG_IDX_W];
	assign wFold = awAddrQ.addr[`BSEL_W +: `FSEL_W];
	assign rFold = arAddrQ.addr[`BSEL_W +: `FSEL_W];
	assign wInRange = wIdx < `REG_IDX_W'(`REG_COUNT);
	assign rInRange = rIdx < `REG_IDX_W'(`REG_COUNT);

	// Write wins over read; bvalid blocks a second issue of the same pair
	assign wrIssue = awHeld && wHeld && !bvalid;
	assign rdIssue = arHeld && !rLock && !wrIssue;

	//----------------------------------------------------------
	// Bank command
	//----------------------------------------------------------
	// Current word merged over the staged folds
	always_comb begin
		commitData = wStage;
		commitData[wFold] = wDataQ.data;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			wStage <= '0;
		else if (wrIssue && wInRange)
			wStage[wFold] <= wDataQ.data;
	end

	// Strobe only on last-fold writes and first-fold reads
	always_ff @(posedge aclk) begin
		if (rst)
			ipEn <= 1'b0;
		else
			ipEn <= (wrIssue && wInRange && (&wFold)) ||
				(rdIssue && rInRange && !(|rFold));
	end

	always_ff @(posedge aclk) begin
		if (wrIssue) begin
			ipCmd.op    <= regCtl_pkg::IP_WRITE;
			ipCmd.idx   <= wIdx;
			ipCmd.wdata <= commitData;
		end else if (rdIssue) begin
			ipCmd.op  <= regCtl_pkg::IP_READ;
			ipCmd.idx <= rIdx;
		end
	end

	//----------------------------------------------------------
	// Replies
	//----------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (rst)
			bvalid <= 1'b0;
		else if (wrIssue)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge aclk) begin
		if (wrIssue)
			bresp <= wInRange ? regCtl_pkg::RESP_OKAY : regCtl_pkg::RESP_SLVERR;
	end

	// Lock keeps the held read from issuing twice
	always_ff @(posedge aclk) begin
		if (rst) begin
			rLock  <= 1'b0;
			intAck <= 1'b0;
		end else begin
			if (rvalid && rready)
				rLock <= 1'b0;
			else if (rdIssue)
				rLock <= 1'b1;
			// Upper folds and bad indices answer without the bank
			intAck <= rdIssue && !(rInRange && !(|rFold));
		end
	end

	// Full 64 bits kept for later upper-word reads
	always_ff @(posedge aclk) begin
		if (rst)
			rKeep <= '0;
		else if (ipRAck)
			rKeep <= ipRData;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (ipRAck || intAck)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// Bank reads are always fold zero
	always_ff @(posedge aclk) begin
		if (ipRAck) begin
			rdata <= ipRData[`BUS_DATA_W-1:0];
			rresp <= regCtl_pkg::RESP_OKAY;
		end else if (intAck) begin
			rdata <= rInRange ? rKeep[rFold] : '0;
			rresp <= rInRange ? regCtl_pkg::RESP_OKAY : regCtl_pkg::RESP_SLVERR;
		end
	end

endmodule

//--- rtl/regCtl_pkg.sv
//----------------------------------------------------------
// Types shared by the AXI4-Lite bridge and the register bank
// Widths come from the consts header
//----------------------------------------------------------
`include "regCtl_consts.svh"

package regCtl_pkg;

	// AXI response codes, only the two in use
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axiResp_e;

	// Bank opcodes
	typedef enum logic {
		IP_READ  = 1'b0,
		IP_WRITE = 1'b1
	} ipOp_e;

	// AW and AR payload, prot is carried but ignored
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [2:0]             prot;
	} axiAddr_t;

	// W payload, strobes are carried but ignored
	typedef struct packed {
		logic [`BUS_DATA_W-1:0]   data;
		logic [`BUS_DATA_W/8-1:0] strb;
	} axiWData_t;

	// Bank command, valid while ipEn is high
	typedef struct packed {
		ipOp_e                  op;
		logic [`REG_IDX_W-1:0]  idx;
		logic [`REG_DATA_W-1:0] wdata;
	} ipCmd_t;

endpackage

//--- include/regCtl_consts.svh
//----------------------------------------------------------
// Bus and register-bank sizing for the register control port
// FOLD must be a power of two, BSEL_W and FSEL_W must agree
// with BUS_DATA_W and FOLD, and the address must cover all fields
//----------------------------------------------------------
`ifndef REGCTL_CONSTS_SVH
`define REGCTL_CONSTS_SVH

// AXI4-Lite side
`define BUS_ADDR_W 6
`define BUS_DATA_W 32

// Register bank side
`define REG_DATA_W 64
`define FOLD 2
`define REG_IDX_W 3
`define REG_COUNT 5
`define ID_VALUE 64'h5245_4743_0001_0002

// Byte-select and fold-select bits inside a byte address
`define BSEL_W 2
`define FSEL_W 1

`endif
